/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_LANES = WORD_W / 8;
    localparam int OFFSET_BITS = $clog2(BYTE_LANES);

    // funct3 codes of the load and store forms
    typedef enum logic [2:0] {
        size_byte   = 3'd0,
        size_half   = 3'd1,
        size_word   = 3'd2,
        size_byte_u = 3'd4,
        size_half_u = 3'd5
    } access_size_e;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_writeback,
        ctrl_refill,
        ctrl_respond
    } ctrl_state_e;

endpackage

`default_nettype wire

/* design/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store #(
    parameter int INDEX_BITS = 11,
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
    input  wire logic                         clk,
    input  wire logic                         rst_b,
    input  wire logic [cache_pkg::ADDR_W-1:0] addr,
    input  wire logic                         tag_write,
    input  wire logic                         new_dirty,
    input  wire logic                         mark_dirty,
    output logic                              hit,
    output logic                              victim_dirty,
    output logic [TAG_W-1:0]                  victim_tag
);
    import cache_pkg::*;

    localparam int NUM_LINES = 2 ** INDEX_BITS;

    logic [NUM_LINES-1:0]  valid;
    logic [NUM_LINES-1:0]  dirty;
    logic [TAG_W-1:0]      tags [NUM_LINES];
    logic [INDEX_BITS-1:0] index;
    logic [TAG_W-1:0]      tag;

    assign index = addr[OFFSET_BITS +: INDEX_BITS];
    assign tag = addr[ADDR_W-1 -: TAG_W];

    // lookup of the indexed line
    assign hit = valid[index] && (tags[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag = tags[index];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_write) begin
            valid[index] <= 1'b1;
            dirty[index] <= new_dirty;
        end else if (mark_dirty) begin
            dirty[index] <= 1'b1;
        end
    end

    // tag of the line being installed
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[index] <= tag;
        end
    end

endmodule

`default_nettype wire

/* design/cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_store #(
    parameter int INDEX_BITS = 11
) (
    input  wire logic                             clk,
    input  wire logic [cache_pkg::ADDR_W-1:0]     addr,
    input  wire logic [cache_pkg::BYTE_LANES-1:0] byte_en,
    input  wire logic [cache_pkg::WORD_W-1:0]     write_word,
    output logic [cache_pkg::WORD_W-1:0]          read_word
);
    import cache_pkg::*;

    localparam int NUM_LINES = 2 ** INDEX_BITS;

    logic [WORD_W-1:0]     words [NUM_LINES];
    logic [INDEX_BITS-1:0] index;

    assign index = addr[OFFSET_BITS +: INDEX_BITS];

    // combinational read of the indexed word
    assign read_word = words[index];

    // untouched lanes keep their bytes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (byte_en[lane]) begin
                words[index][8*lane +: 8] <= write_word[8*lane +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* design/cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
    parameter int INDEX_BITS = 11,
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
    input  wire logic                             clk,
    input  wire logic                             rst_b,
    // processor side
    input  wire logic                             req,
    input  wire logic                             we,
    input  wire logic [cache_pkg::ADDR_W-1:0]     addr,
    input  wire cache_pkg::access_size_e          funct3,
    input  wire logic [cache_pkg::WORD_W-1:0]     wdata,
    output logic [cache_pkg::WORD_W-1:0]          rdata,
    output logic                                  done,
    // tag and data store
    input  wire logic                             hit,
    input  wire logic                             victim_dirty,
    input  wire logic [TAG_W-1:0]                 victim_tag,
    input  wire logic [cache_pkg::WORD_W-1:0]     read_word,
    output logic                                  tag_write,
    output logic                                  new_dirty,
    output logic                                  mark_dirty,
    output logic [cache_pkg::BYTE_LANES-1:0]      byte_en,
    output logic [cache_pkg::WORD_W-1:0]          write_word,
    // memory side
    output logic                                  mem_req,
    output logic                                  mem_we,
    output logic [cache_pkg::ADDR_W-1:0]          mem_addr,
    output logic [cache_pkg::WORD_W-1:0]          mem_wdata,
    input  wire logic [cache_pkg::WORD_W-1:0]     mem_rdata,
    input  wire logic                             mem_done
);
    import cache_pkg::*;

    ctrl_state_e            state;
    logic                   mem_req_q;
    logic                   mem_ack;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
    logic [OFFSET_BITS+2:0] shift_amt;
    logic [BYTE_LANES-1:0]  store_lanes;
    logic [WORD_W-1:0]      load_word;

    assign index = addr[OFFSET_BITS +: INDEX_BITS];
    assign offset = addr[OFFSET_BITS-1:0];
    assign shift_amt = {offset, 3'b000};
    assign mem_ack = mem_req_q & mem_done;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= ctrl_idle;
            mem_req_q <= 1'b0;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (req) begin
                        if (hit) begin
                            state <= ctrl_respond;
                        end else begin
                            // dirty victim goes out before the refill
                            mem_req_q <= 1'b1;
                            state <= victim_dirty ? ctrl_writeback : ctrl_refill;
                        end
                    end
                end
                ctrl_writeback: begin
                    if (mem_ack) begin
                        mem_req_q <= 1'b0;
                        state <= ctrl_refill;
                    end
                end
                ctrl_refill: begin
                    // re-raised after the gap cycle that follows a writeback
                    if (mem_ack) begin
                        mem_req_q <= 1'b0;
                        state <= ctrl_respond;
                    end else begin
                        mem_req_q <= 1'b1;
                    end
                end
                ctrl_respond: begin
                    state <= ctrl_idle;
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // memory port, whole words only
    assign mem_req = mem_req_q;
    assign mem_we = (state == ctrl_writeback);
    assign mem_addr = (state == ctrl_writeback)
                    ? {victim_tag, index, {OFFSET_BITS{1'b0}}}
                    : {addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_wdata = read_word;

    assign done = (state == ctrl_respond);

    // lanes touched by a store before the offset shift
    always_comb begin
        case (funct3)
            size_byte: store_lanes = 4'b0001;
            size_half: store_lanes = 4'b0011;
            size_word: store_lanes = 4'b1111;
            default:   store_lanes = 4'b0000;
        endcase
    end

    always_comb begin
        tag_write = 1'b0;
        new_dirty = 1'b0;
        mark_dirty = 1'b0;
        byte_en = '0;
        write_word = mem_rdata;
        if (state == ctrl_refill && mem_ack) begin
            // install the refilled word clean
            tag_write = 1'b1;
            new_dirty = 1'b0;
            byte_en = '1;
        end else if (state == ctrl_respond && we) begin
            byte_en = store_lanes << offset;
            write_word = wdata << shift_amt;
            mark_dirty = |store_lanes;
        end
    end

    // align to the byte offset and extend
    assign load_word = read_word >> shift_amt;

    always_comb begin
        case (funct3)
            size_byte:   rdata = {{(WORD_W-8){load_word[7]}}, load_word[7:0]};
            size_half:   rdata = {{(WORD_W-16){load_word[15]}}, load_word[15:0]};
            size_word:   rdata = load_word;
            size_byte_u: rdata = {{(WORD_W-8){1'b0}}, load_word[7:0]};
            size_half_u: rdata = {{(WORD_W-16){1'b0}}, load_word[15:0]};
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int INDEX_BITS = 11
) (
    input  wire logic                         clk,
    input  wire logic                         rst_b,
    // processor side
    input  wire logic                         req,
    input  wire logic                         we,
    input  wire logic [cache_pkg::ADDR_W-1:0] addr,
    input  wire logic [2:0]                   funct3,
    input  wire logic [cache_pkg::WORD_W-1:0] wdata,
    output logic [cache_pkg::WORD_W-1:0]      rdata,
    output logic                              done,
    // memory side
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [cache_pkg::ADDR_W-1:0]      mem_addr,
    output logic [cache_pkg::WORD_W-1:0]      mem_wdata,
    input  wire logic [cache_pkg::WORD_W-1:0] mem_rdata,
    input  wire logic                         mem_done
);
    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_BITS - OFFSET_BITS;

    logic                  hit;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    logic [WORD_W-1:0]     read_word;
    logic                  tag_write;
    logic                  new_dirty;
    logic                  mark_dirty;
    logic [BYTE_LANES-1:0] byte_en;
    logic [WORD_W-1:0]     write_word;

    cache_tag_store #(
        .INDEX_BITS   (INDEX_BITS)
    ) i_cache_tag_store (
        .clk          (clk),
        .rst_b        (rst_b),
        .addr         (addr),
        .tag_write    (tag_write),
        .new_dirty    (new_dirty),
        .mark_dirty   (mark_dirty),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_store #(
        .INDEX_BITS (INDEX_BITS)
    ) i_cache_data_store (
        .clk        (clk),
        .addr       (addr),
        .byte_en    (byte_en),
        .write_word (write_word),
        .read_word  (read_word)
    );

    cache_controller #(
        .INDEX_BITS   (INDEX_BITS)
    ) i_cache_controller (
        .clk          (clk),
        .rst_b        (rst_b),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .funct3       (access_size_e'(funct3)),
        .wdata        (wdata),
        .rdata        (rdata),
        .done         (done),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .read_word    (read_word),
        .tag_write    (tag_write),
        .new_dirty    (new_dirty),
        .mark_dirty   (mark_dirty),
        .byte_en      (byte_en),
        .write_word   (write_word),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_done     (mem_done)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free-running clock that starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* sim/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int MAX_LINES = 64;
    localparam int FIELDS = 6;
    localparam logic [31:0] END_MARK = 32'hf;

    logic        clk;
    logic        rst_b = 1'b0;
    logic        req = 1'b0;
    logic        we = 1'b0;
    logic [31:0] addr = '0;
    logic [2:0]  funct3 = '0;
    logic [31:0] wdata = '0;
    logic [31:0] rdata;
    logic        done;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata = '0;
    logic        mem_done = 1'b0;

    // six words per access in the order of the file columns
    logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
    int          num_lines = 0;
    int          current_line = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    // sparse memory model
    logic [31:0] mem_words [logic [31:0]];
    integer      seed = 32'h573b_395a;
    logic [31:0] rnd;
    logic        mem_busy = 1'b0;
    logic [1:0]  mem_wait = 2'd0;
    int          ops_count = 0;

    tb_clock #(
        .PERIOD_NS (100)
    ) i_tb_clock (
        .clk (clk)
    );

    cache_top #(
        .INDEX_BITS (4)
    ) i_cache_top (
        .clk       (clk),
        .rst_b     (rst_b),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .funct3    (funct3),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_done  (mem_done)
    );

    // answers each request after 1 to 4 cycles
    always @(posedge clk) begin
        if (!rst_b) begin
            mem_done <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_done) begin
            mem_done <= 1'b0;
        end else if (mem_req && !mem_busy) begin
            rnd = $random(seed);
            mem_wait <= rnd[1:0];
            mem_busy <= 1'b1;
        end else if (mem_busy) begin
            if (mem_wait == 2'd0) begin
                mem_busy <= 1'b0;
                mem_done <= 1'b1;
                ops_count <= ops_count + 1;
                if (mem_we) begin
                    mem_words[mem_addr] = mem_wdata;
                end else begin
                    // unwritten words read back as their own address
                    mem_rdata <= mem_words.exists(mem_addr) ? mem_words[mem_addr] : mem_addr;
                end
            end else begin
                mem_wait <= mem_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run took more than %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("error at %0t: line %0d %s is %h, expected %h",
                     $time, current_line, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    task automatic load_stimulus();
        logic found;
        int   i;
        found = 1'b0;
        $readmemh("sim/cache_stimulus.txt", stim_mem);
        for (i = 0; i < MAX_LINES; i++) begin
            if (!found && stim_mem[FIELDS*i] == END_MARK) begin
                found = 1'b1;
                num_lines = i;
            end
        end
        if (!found || num_lines == 0) begin
            $display("stimulus file holds no accesses or lacks its end line");
            $display("Verification failed");
            $fatal(1, "stimulus could not be read");
        end else begin
            cycle_limit = num_lines * 12 + 50;
        end
    endtask

    task automatic run_access(input int line);
        logic [31:0] f_we;
        logic [31:0] f_funct3;
        logic [31:0] f_ops;
        logic [31:0] f_expect;
        int          ops_before;
        int          cycles;
        f_we = stim_mem[FIELDS*line];
        f_funct3 = stim_mem[FIELDS*line+1];
        f_ops = stim_mem[FIELDS*line+2];
        f_expect = stim_mem[FIELDS*line+5];
        current_line = line;
        ops_before = ops_count;
        cycles = 0;
        @(posedge clk);
        req <= 1'b1;
        we <= f_we[0];
        funct3 <= f_funct3[2:0];
        addr <= stim_mem[FIELDS*line+3];
        wdata <= stim_mem[FIELDS*line+4];
        // outputs are sampled on the falling edge
        do begin
            @(negedge clk);
            cycles++;
            if (f_ops == 0) begin
                expect_equal(32'(mem_req), 32'd0, "mem_req on a hit");
            end
        end while (!done);
        // a hit answers one cycle after req is sampled
        if (f_ops == 0) begin
            expect_equal(32'(cycles), 32'd2, "hit latency in cycles");
        end
        expect_equal(32'(ops_count - ops_before), f_ops, "memory transfer count");
        if (!f_we[0]) begin
            expect_equal(rdata, f_expect, "load data");
        end
    endtask

    initial begin
        int line;
        load_stimulus();
        repeat (5) @(posedge clk);
        rst_b <= 1'b1;
        for (line = 0; line < num_lines; line++) begin
            run_access(line);
        end
        @(posedge clk);
        req <= 1'b0;
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cache_stimulus.txt */
// we funct3 mem_ops addr wdata expected_rdata, all hex
// mem_ops is the number of memory transfers, 0 for a hit; a we of f ends the list
0 0 1 8a7ff065 00000000 fffffff0
0 2 0 8a7ff064 00000000 8a7ff064
0 0 0 8a7ff064 00000000 00000064
0 0 0 8a7ff066 00000000 0000007f
0 0 0 8a7ff067 00000000 ffffff8a
0 4 0 8a7ff065 00000000 000000f0
0 4 0 8a7ff067 00000000 0000008a
0 1 0 8a7ff064 00000000 fffff064
0 1 0 8a7ff066 00000000 ffff8a7f
0 5 0 8a7ff064 00000000 0000f064
0 5 0 8a7ff066 00000000 00008a7f
// stores merge into a hit line
1 2 0 8a7ff064 13579bdf 00000000
0 2 0 8a7ff064 00000000 13579bdf
1 0 0 8a7ff066 000000c3 00000000
0 2 0 8a7ff064 00000000 13c39bdf
1 1 0 8a7ff064 ffff1234 00000000
0 2 0 8a7ff064 00000000 13c31234
1 0 0 8a7ff065 aabbcc5a 00000000
0 2 0 8a7ff064 00000000 13c35a34
1 1 0 8a7ff066 0000beef 00000000
0 2 0 8a7ff064 00000000 beef5a34
// conflict on index 9 writes the dirty word back
0 2 2 12345664 00000000 12345664
0 2 1 8a7ff064 00000000 beef5a34
// store miss allocates on index 10
1 0 1 0f0f0f2b 000000a5 00000000
0 2 0 0f0f0f28 00000000 a50f0f28
0 0 0 0f0f0f2b 00000000 ffffffa5
0 2 2 777777e8 00000000 777777e8
0 2 1 0f0f0f28 00000000 a50f0f28
1 1 1 777777ea 00004321 00000000
0 5 0 777777ea 00000000 00004321
// unsupported funct3 codes
0 3 0 777777e8 00000000 00000000
1 7 0 777777e8 ffffffff 00000000
0 2 0 777777e8 00000000 432177e8
0 6 0 8a7ff064 00000000 00000000
0 3 1 2468acf0 00000000 00000000
0 2 0 2468acf0 00000000 2468acf0
1 6 0 2468acf0 11111111 00000000
0 2 0 2468acf0 00000000 2468acf0
0 2 1 3468acf0 00000000 3468acf0
f 0 0 00000000 00000000 00000000

/* all.f */
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_controller.sv
design/cache_top.sv
sim/tb_clock.sv
sim/cache_tb.sv

/* Makefile */
TOP = cache_tb

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
